// ==== src/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int XLEN   = 32;	// data and address width
	localparam int REG_AW = 5;	// register index width

	// ------------------------------
	// encodings
	// ------------------------------
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		CMP_NOP, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
	} cmp_op_e;

	typedef enum logic [3:0] {
		MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	typedef enum logic [1:0] {
		WB_ALU,		// alu result
		WB_CMP,		// compare bit, zero extended
		WB_LINK,	// pc+4 or U immediate from decode
		WB_MEM		// load data
	} wb_sel_e;

	function automatic logic mem_is_load(input mem_op_e op);
		return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	endfunction

	// ------------------------------
	// stage bundles
	// ------------------------------
	typedef struct packed {
		logic              valid;
		alu_op_e           alu_op;
		cmp_op_e           cmp_op;
		logic [XLEN-1:0]   alu_a;
		logic [XLEN-1:0]   alu_b;
		logic [XLEN-1:0]   cmp_a;
		logic [XLEN-1:0]   cmp_b;
		mem_op_e           mem_op;
		logic [XLEN-1:0]   store_data;
		wb_sel_e           wb_sel;
		logic              gpr_we;
		logic [REG_AW-1:0] dst;
		logic [XLEN-1:0]   link_data;
		logic              is_branch;
		logic              is_jump;
	} id_ex_t;

	typedef struct packed {
		logic              valid;
		logic              gpr_we;
		logic [REG_AW-1:0] dst;
		wb_sel_e           wb_sel;
		logic [XLEN-1:0]   ex_result;
		mem_op_e           mem_op;
		logic [XLEN-1:0]   mem_addr;
		logic [XLEN-1:0]   store_data;
	} ex_mem_t;

	typedef struct packed {
		logic              valid;
		logic              gpr_we;
		logic [REG_AW-1:0] dst;
		logic [XLEN-1:0]   data;
	} fwd_t;

endpackage

// ==== src/gpr_file.sv ====
module gpr_file (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  logic [rv_pipe_pkg::REG_AW-1:0] rd_addr_a_i,
	input  logic [rv_pipe_pkg::REG_AW-1:0] rd_addr_b_i,
	input  logic                           we_i,
	input  logic [rv_pipe_pkg::REG_AW-1:0] wr_addr_i,
	input  logic [rv_pipe_pkg::XLEN-1:0]   wr_data_i,
	output logic [rv_pipe_pkg::XLEN-1:0]   rd_data_a_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   rd_data_b_o
);

	logic [rv_pipe_pkg::XLEN-1:0] regs [0:31];

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		else if (we_i && wr_addr_i != '0)
			regs[wr_addr_i] <= wr_data_i;	// x0 stays zero
	end

	// write-through on same-cycle read
	assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 :
		(we_i && wr_addr_i == rd_addr_a_i) ? wr_data_i : regs[rd_addr_a_i];
	assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 :
		(we_i && wr_addr_i == rd_addr_b_i) ? wr_data_i : regs[rd_addr_b_i];

endmodule

// ==== src/decoder.sv ====
module decoder (
	input  logic                             insn_valid_i,
	input  logic [rv_pipe_pkg::XLEN-1:0]     pc_i,
	input  logic [31:0]                      insn_i,
	input  logic [rv_pipe_pkg::XLEN-1:0]     rd_data_a_i,
	input  logic [rv_pipe_pkg::XLEN-1:0]     rd_data_b_i,
	input  rv_pipe_pkg::fwd_t                ex_fwd_i,
	input  rv_pipe_pkg::fwd_t                mem_fwd_i,
	input  rv_pipe_pkg::fwd_t                ex_load_i,
	input  logic                             flush_i,
	output logic [rv_pipe_pkg::REG_AW-1:0]   rd_addr_a_o,
	output logic [rv_pipe_pkg::REG_AW-1:0]   rd_addr_b_o,
	output rv_pipe_pkg::id_ex_t              id_ex_o,
	output logic                             stall_o
);

	rv_pipe_pkg::opcode_e opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rv_pipe_pkg::REG_AW-1:0] rs1;
	logic [rv_pipe_pkg::REG_AW-1:0] rs2;
	logic [rv_pipe_pkg::XLEN-1:0] imm_i;
	logic [rv_pipe_pkg::XLEN-1:0] imm_sh;
	logic [rv_pipe_pkg::XLEN-1:0] imm_s;
	logic [rv_pipe_pkg::XLEN-1:0] imm_b;
	logic [rv_pipe_pkg::XLEN-1:0] imm_j;
	logic [rv_pipe_pkg::XLEN-1:0] imm_u;
	logic [rv_pipe_pkg::XLEN-1:0] op_a;
	logic [rv_pipe_pkg::XLEN-1:0] op_b;
	logic sh_ok;
	logic legal;

	// ------------------------------
	// fields and immediates
	// ------------------------------
	assign opc    = rv_pipe_pkg::opcode_e'(insn_i[6:0]);
	assign funct3 = insn_i[14:12];
	assign funct7 = insn_i[31:25];
	assign rs1    = insn_i[19:15];
	assign rs2    = insn_i[24:20];
	assign imm_i  = {{20{insn_i[31]}}, insn_i[31:20]};
	assign imm_sh = {27'b0, insn_i[24:20]};	// shamt only
	assign imm_s  = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
	assign imm_b  = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
	assign imm_j  = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
	assign imm_u  = {insn_i[31:12], 12'b0};

	assign rd_addr_a_o = rs1;
	assign rd_addr_b_o = rs2;

	// funct7 of 0x20 only selects SUB or SRA
	assign sh_ok = (funct7 == 7'h00) || ((funct7 == 7'h20) &&
		((funct3 == 3'd5) || (funct3 == 3'd0 && opc == rv_pipe_pkg::OPC_OP)));

	// ------------------------------
	// operand forwarding
	// ------------------------------
	function automatic logic [rv_pipe_pkg::XLEN-1:0] fwd_pick(
		input logic [rv_pipe_pkg::REG_AW-1:0] addr,
		input logic [rv_pipe_pkg::XLEN-1:0]   rf_data,
		input rv_pipe_pkg::fwd_t              ex_f,
		input rv_pipe_pkg::fwd_t              mem_f
	);
		if (addr == '0)
			return rf_data;
		if (ex_f.valid && ex_f.gpr_we && ex_f.dst == addr)
			return ex_f.data;	// youngest producer wins
		if (mem_f.valid && mem_f.gpr_we && mem_f.dst == addr)
			return mem_f.data;
		return rf_data;
	endfunction

	assign op_a = fwd_pick(rs1, rd_data_a_i, ex_fwd_i, mem_fwd_i);
	assign op_b = fwd_pick(rs2, rd_data_b_i, ex_fwd_i, mem_fwd_i);

	// load result is not ready until the next cycle
	assign stall_o = insn_valid_i && ex_load_i.valid && ex_load_i.gpr_we &&
		(ex_load_i.dst != '0) && (ex_load_i.dst == rs1 || ex_load_i.dst == rs2);

	// ------------------------------
	// decode
	// ------------------------------
	always_comb
	begin
		id_ex_o            = '0;
		id_ex_o.alu_a      = op_a;
		id_ex_o.alu_b      = op_b;
		id_ex_o.cmp_a      = op_a;
		id_ex_o.cmp_b      = op_b;
		id_ex_o.store_data = op_b;
		id_ex_o.dst        = insn_i[11:7];
		id_ex_o.link_data  = pc_i + 32'd4;	// return address
		legal              = 1'b1;
		case (opc)
			rv_pipe_pkg::OPC_LUI:
			begin
				id_ex_o.gpr_we    = 1'b1;
				id_ex_o.wb_sel    = rv_pipe_pkg::WB_LINK;
				id_ex_o.link_data = imm_u;
			end
			rv_pipe_pkg::OPC_AUIPC:
			begin
				id_ex_o.alu_op = rv_pipe_pkg::ALU_ADD;
				id_ex_o.alu_a  = pc_i;
				id_ex_o.alu_b  = imm_u;
				id_ex_o.gpr_we = 1'b1;
			end
			rv_pipe_pkg::OPC_JAL, rv_pipe_pkg::OPC_JALR:
			begin
				id_ex_o.alu_op  = rv_pipe_pkg::ALU_ADD;
				id_ex_o.gpr_we  = 1'b1;
				id_ex_o.wb_sel  = rv_pipe_pkg::WB_LINK;
				id_ex_o.is_jump = 1'b1;
				if (opc == rv_pipe_pkg::OPC_JAL)
				begin
					id_ex_o.alu_a = pc_i;
					id_ex_o.alu_b = imm_j;
				end
				else
				begin
					id_ex_o.alu_b = imm_i;	// rs1 + imm
					legal         = (funct3 == 3'd0);
				end
			end
			rv_pipe_pkg::OPC_BRANCH:
			begin
				id_ex_o.alu_op    = rv_pipe_pkg::ALU_ADD;
				id_ex_o.alu_a     = pc_i;
				id_ex_o.alu_b     = imm_b;
				id_ex_o.is_branch = 1'b1;
				case (funct3)
					3'd0: id_ex_o.cmp_op = rv_pipe_pkg::CMP_EQ;
					3'd1: id_ex_o.cmp_op = rv_pipe_pkg::CMP_NE;
					3'd4: id_ex_o.cmp_op = rv_pipe_pkg::CMP_LT;
					3'd5: id_ex_o.cmp_op = rv_pipe_pkg::CMP_GE;
					3'd6: id_ex_o.cmp_op = rv_pipe_pkg::CMP_LTU;
					3'd7: id_ex_o.cmp_op = rv_pipe_pkg::CMP_GEU;
					default: legal = 1'b0;
				endcase
			end
			rv_pipe_pkg::OPC_LOAD:
			begin
				id_ex_o.alu_op = rv_pipe_pkg::ALU_ADD;
				id_ex_o.alu_b  = imm_i;
				id_ex_o.gpr_we = 1'b1;
				id_ex_o.wb_sel = rv_pipe_pkg::WB_MEM;
				case (funct3)
					3'd0: id_ex_o.mem_op = rv_pipe_pkg::MEM_LB;
					3'd1: id_ex_o.mem_op = rv_pipe_pkg::MEM_LH;
					3'd2: id_ex_o.mem_op = rv_pipe_pkg::MEM_LW;
					3'd4: id_ex_o.mem_op = rv_pipe_pkg::MEM_LBU;
					3'd5: id_ex_o.mem_op = rv_pipe_pkg::MEM_LHU;
					default: legal = 1'b0;
				endcase
			end
			rv_pipe_pkg::OPC_STORE:
			begin
				id_ex_o.alu_op = rv_pipe_pkg::ALU_ADD;
				id_ex_o.alu_b  = imm_s;
				case (funct3)
					3'd0: id_ex_o.mem_op = rv_pipe_pkg::MEM_SB;
					3'd1: id_ex_o.mem_op = rv_pipe_pkg::MEM_SH;
					3'd2: id_ex_o.mem_op = rv_pipe_pkg::MEM_SW;
					default: legal = 1'b0;
				endcase
			end
			rv_pipe_pkg::OPC_OP_IMM, rv_pipe_pkg::OPC_OP:
			begin
				id_ex_o.gpr_we = 1'b1;
				legal          = sh_ok;
				if (opc == rv_pipe_pkg::OPC_OP_IMM)
				begin
					id_ex_o.alu_b = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
					id_ex_o.cmp_b = imm_i;
					legal = (funct3 == 3'd1) ? (funct7 == 7'h00) : (funct3 != 3'd5 || sh_ok);
				end
				if (funct3[2:1] == 2'b01)
					id_ex_o.wb_sel = rv_pipe_pkg::WB_CMP;	// slt family
				case (funct3)
					3'd0: id_ex_o.alu_op = (opc == rv_pipe_pkg::OPC_OP && funct7[5]) ?
						rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
					3'd1: id_ex_o.alu_op = rv_pipe_pkg::ALU_SLL;
					3'd2: id_ex_o.cmp_op = rv_pipe_pkg::CMP_LT;
					3'd3: id_ex_o.cmp_op = rv_pipe_pkg::CMP_LTU;
					3'd4: id_ex_o.alu_op = rv_pipe_pkg::ALU_XOR;
					3'd5: id_ex_o.alu_op = funct7[5] ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
					3'd6: id_ex_o.alu_op = rv_pipe_pkg::ALU_OR;
					default: id_ex_o.alu_op = rv_pipe_pkg::ALU_AND;
				endcase
			end
			default: legal = 1'b0;	// undefined opcode
		endcase
		id_ex_o.valid  = insn_valid_i && legal && !stall_o && !flush_i;
		id_ex_o.gpr_we = id_ex_o.gpr_we && id_ex_o.valid && (id_ex_o.dst != '0);
	end

endmodule

// ==== src/ex_stage.sv ====
module ex_stage (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  rv_pipe_pkg::id_ex_t          id_ex_i,
	output rv_pipe_pkg::ex_mem_t         ex_mem_o,
	output rv_pipe_pkg::fwd_t            ex_fwd_o,
	output rv_pipe_pkg::fwd_t            ex_load_o,
	output logic                         br_taken_o,
	output logic [rv_pipe_pkg::XLEN-1:0] br_addr_o
);

	rv_pipe_pkg::id_ex_t id_ex_q;
	logic [rv_pipe_pkg::XLEN-1:0] alu_res;
	logic [rv_pipe_pkg::XLEN-1:0] result;
	logic cmp_res;
	logic is_load;

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			id_ex_q <= '0;	// bubble
		else
			id_ex_q <= id_ex_i;
	end

	// ------------------------------
	// alu and comparator
	// ------------------------------
	always_comb
	begin
		case (id_ex_q.alu_op)
			rv_pipe_pkg::ALU_ADD: alu_res = id_ex_q.alu_a + id_ex_q.alu_b;
			rv_pipe_pkg::ALU_SUB: alu_res = id_ex_q.alu_a - id_ex_q.alu_b;
			rv_pipe_pkg::ALU_SLL: alu_res = id_ex_q.alu_a << id_ex_q.alu_b[4:0];
			rv_pipe_pkg::ALU_XOR: alu_res = id_ex_q.alu_a ^ id_ex_q.alu_b;
			rv_pipe_pkg::ALU_SRL: alu_res = id_ex_q.alu_a >> id_ex_q.alu_b[4:0];
			rv_pipe_pkg::ALU_SRA: alu_res = $signed(id_ex_q.alu_a) >>> id_ex_q.alu_b[4:0];
			rv_pipe_pkg::ALU_OR:  alu_res = id_ex_q.alu_a | id_ex_q.alu_b;
			rv_pipe_pkg::ALU_AND: alu_res = id_ex_q.alu_a & id_ex_q.alu_b;
			default:              alu_res = '0;
		endcase
		case (id_ex_q.cmp_op)
			rv_pipe_pkg::CMP_EQ:  cmp_res = id_ex_q.cmp_a == id_ex_q.cmp_b;
			rv_pipe_pkg::CMP_NE:  cmp_res = id_ex_q.cmp_a != id_ex_q.cmp_b;
			rv_pipe_pkg::CMP_LT:  cmp_res = $signed(id_ex_q.cmp_a) < $signed(id_ex_q.cmp_b);
			rv_pipe_pkg::CMP_GE:  cmp_res = $signed(id_ex_q.cmp_a) >= $signed(id_ex_q.cmp_b);
			rv_pipe_pkg::CMP_LTU: cmp_res = id_ex_q.cmp_a < id_ex_q.cmp_b;
			rv_pipe_pkg::CMP_GEU: cmp_res = id_ex_q.cmp_a >= id_ex_q.cmp_b;
			default:              cmp_res = 1'b0;
		endcase
		case (id_ex_q.wb_sel)
			rv_pipe_pkg::WB_CMP:  result = {31'b0, cmp_res};
			rv_pipe_pkg::WB_LINK: result = id_ex_q.link_data;
			default:              result = alu_res;	// alu, or address for loads
		endcase
	end

	// redirect, jalr target has bit 0 cleared
	assign br_taken_o = id_ex_q.valid && (id_ex_q.is_jump || (id_ex_q.is_branch && cmp_res));
	assign br_addr_o  = {alu_res[rv_pipe_pkg::XLEN-1:1], alu_res[0] & ~id_ex_q.is_jump};

	assign is_load = rv_pipe_pkg::mem_is_load(id_ex_q.mem_op);

	assign ex_mem_o = '{valid: id_ex_q.valid, gpr_we: id_ex_q.gpr_we, dst: id_ex_q.dst,
		wb_sel: id_ex_q.wb_sel, ex_result: result, mem_op: id_ex_q.mem_op,
		mem_addr: alu_res, store_data: id_ex_q.store_data};
	assign ex_fwd_o  = '{valid: id_ex_q.valid && !is_load, gpr_we: id_ex_q.gpr_we,
		dst: id_ex_q.dst, data: result};
	assign ex_load_o = '{valid: id_ex_q.valid && is_load, gpr_we: id_ex_q.gpr_we,
		dst: id_ex_q.dst, data: alu_res};

endmodule

// ==== src/mem_stage.sv ====
module mem_stage (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  rv_pipe_pkg::ex_mem_t           ex_mem_i,
	input  logic [rv_pipe_pkg::XLEN-1:0]   mem_rdata_i,
	output rv_pipe_pkg::mem_op_e           mem_op_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   mem_addr_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   mem_wdata_o,
	output rv_pipe_pkg::fwd_t              mem_fwd_o,
	output logic                           wb_valid_o,
	output logic [rv_pipe_pkg::REG_AW-1:0] wb_addr_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   wb_data_o
);

	logic [4:0] lane_sh;
	logic [rv_pipe_pkg::XLEN-1:0] ld_raw;
	logic [rv_pipe_pkg::XLEN-1:0] ld_data;
	logic wb_we_q;
	logic [rv_pipe_pkg::REG_AW-1:0] wb_dst_q;
	logic [rv_pipe_pkg::XLEN-1:0] wb_data_q;

	assign lane_sh    = {ex_mem_i.mem_addr[1:0], 3'b000};	// byte offset in bits
	assign mem_op_o   = ex_mem_i.valid ? ex_mem_i.mem_op : rv_pipe_pkg::MEM_NOP;
	assign mem_addr_o = ex_mem_i.mem_addr;
	assign ld_raw     = mem_rdata_i >> lane_sh;

	always_comb
	begin
		case (ex_mem_i.mem_op)
			rv_pipe_pkg::MEM_SB: mem_wdata_o = {24'b0, ex_mem_i.store_data[7:0]} << lane_sh;
			rv_pipe_pkg::MEM_SH: mem_wdata_o = {16'b0, ex_mem_i.store_data[15:0]} << lane_sh;
			default:             mem_wdata_o = ex_mem_i.store_data;
		endcase
		case (ex_mem_i.mem_op)
			rv_pipe_pkg::MEM_LB:  ld_data = {{24{ld_raw[7]}}, ld_raw[7:0]};
			rv_pipe_pkg::MEM_LH:  ld_data = {{16{ld_raw[15]}}, ld_raw[15:0]};
			rv_pipe_pkg::MEM_LBU: ld_data = {24'b0, ld_raw[7:0]};
			rv_pipe_pkg::MEM_LHU: ld_data = {16'b0, ld_raw[15:0]};
			default:              ld_data = ld_raw;	// word
		endcase
	end

	// ------------------------------
	// writeback register
	// ------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			wb_we_q <= 1'b0;
		else
			wb_we_q <= ex_mem_i.valid && ex_mem_i.gpr_we;
	end

	always_ff @(posedge clk_i)
	begin
		wb_dst_q  <= ex_mem_i.dst;
		wb_data_q <= (ex_mem_i.wb_sel == rv_pipe_pkg::WB_MEM) ? ld_data : ex_mem_i.ex_result;
	end

	assign mem_fwd_o  = '{valid: wb_we_q, gpr_we: wb_we_q, dst: wb_dst_q, data: wb_data_q};
	assign wb_valid_o = wb_we_q;
	assign wb_addr_o  = wb_dst_q;
	assign wb_data_o  = wb_data_q;

endmodule

// ==== src/rv_pipe_top.sv ====
module rv_pipe_top (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  logic                           insn_valid_i,
	input  logic [rv_pipe_pkg::XLEN-1:0]   pc_i,
	input  logic [31:0]                    insn_i,
	output logic                           stall_o,
	output logic                           br_taken_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   br_addr_o,
	output rv_pipe_pkg::mem_op_e           mem_op_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   mem_addr_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   mem_wdata_o,
	input  logic [rv_pipe_pkg::XLEN-1:0]   mem_rdata_i,
	output logic                           wb_valid_o,
	output logic [rv_pipe_pkg::REG_AW-1:0] wb_addr_o,
	output logic [rv_pipe_pkg::XLEN-1:0]   wb_data_o
);

	logic [rv_pipe_pkg::REG_AW-1:0] rd_addr_a;
	logic [rv_pipe_pkg::REG_AW-1:0] rd_addr_b;
	logic [rv_pipe_pkg::XLEN-1:0] rd_data_a;
	logic [rv_pipe_pkg::XLEN-1:0] rd_data_b;
	rv_pipe_pkg::id_ex_t id_ex;
	rv_pipe_pkg::ex_mem_t ex_mem;
	rv_pipe_pkg::fwd_t ex_fwd;
	rv_pipe_pkg::fwd_t ex_load;
	rv_pipe_pkg::fwd_t mem_fwd;

	decoder u_decoder (.insn_valid_i(insn_valid_i), .pc_i(pc_i), .insn_i(insn_i),
		.rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b), .ex_fwd_i(ex_fwd),
		.mem_fwd_i(mem_fwd), .ex_load_i(ex_load), .flush_i(br_taken_o),
		.rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b), .id_ex_o(id_ex), .stall_o(stall_o));

	gpr_file u_gpr_file (.clk_i(clk_i), .arst_n_i(arst_n_i), .rd_addr_a_i(rd_addr_a),
		.rd_addr_b_i(rd_addr_b), .we_i(mem_fwd.gpr_we), .wr_addr_i(mem_fwd.dst),
		.wr_data_i(mem_fwd.data), .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b));

	ex_stage u_ex_stage (.clk_i(clk_i), .arst_n_i(arst_n_i), .id_ex_i(id_ex),
		.ex_mem_o(ex_mem), .ex_fwd_o(ex_fwd), .ex_load_o(ex_load),
		.br_taken_o(br_taken_o), .br_addr_o(br_addr_o));

	mem_stage u_mem_stage (.clk_i(clk_i), .arst_n_i(arst_n_i), .ex_mem_i(ex_mem),
		.mem_rdata_i(mem_rdata_i), .mem_op_o(mem_op_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_fwd_o(mem_fwd), .wb_valid_o(wb_valid_o),
		.wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o));

endmodule

// ==== tests/rv_pipe_checker.sv ====
module rv_pipe_checker (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  logic                           stall_o,
	input  logic                           br_taken_o,
	input  logic [rv_pipe_pkg::XLEN-1:0]   br_addr_o,
	input  rv_pipe_pkg::mem_op_e           mem_op_o,
	input  logic                           wb_valid_o,
	input  logic [rv_pipe_pkg::REG_AW-1:0] wb_addr_o,
	input  rv_pipe_pkg::fwd_t              ex_load_i,
	input  logic [rv_pipe_pkg::REG_AW-1:0] rd_addr_a_i,
	input  logic [rv_pipe_pkg::REG_AW-1:0] rd_addr_b_i
);

	timeunit 1ns;
	timeprecision 100ps;

	logic load_match;

	// load in EX as shown on the data port
	assign load_match = rv_pipe_pkg::mem_is_load(mem_op_o) && (ex_load_i.dst != '0) &&
		(ex_load_i.dst == rd_addr_a_i || ex_load_i.dst == rd_addr_b_i);

	// ------------------------------
	// protocol properties
	// ------------------------------
	wb_no_x0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb_valid_o |-> wb_addr_o != '0)
		else $error("register write to x0 shown on the writeback port");

	stall_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		stall_o |-> load_match)
		else $error("stall without a matching load in EX");

	br_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		br_taken_o |-> !br_addr_o[0])
		else $error("redirect target has bit 0 set");

	reset_quiet: assert property (@(posedge clk_i)
		!arst_n_i |-> (!wb_valid_o && !br_taken_o && !stall_o &&
		mem_op_o == rv_pipe_pkg::MEM_NOP))
		else $error("control outputs active during reset");

endmodule

bind rv_pipe_top rv_pipe_checker u_checker (.clk_i(clk_i), .arst_n_i(arst_n_i),
	.stall_o(stall_o), .br_taken_o(br_taken_o), .br_addr_o(br_addr_o), .mem_op_o(mem_op_o),
	.wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .ex_load_i(ex_load),
	.rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b));

// ==== tests/rv_pipe_tb.sv ====
module rv_pipe_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [4:0]  addr;
		logic [31:0] data;
	} wr_t;

	logic clk = 1'b0;
	logic arst_n_i;
	logic insn_valid_i;
	logic [31:0] pc_i;
	logic [31:0] insn_i;
	logic stall_o;
	logic br_taken_o;
	logic [31:0] br_addr_o;
	rv_pipe_pkg::mem_op_e mem_op_o;
	logic [31:0] mem_addr_o;
	logic [31:0] mem_wdata_o;
	logic [31:0] mem_rdata_i;
	logic wb_valid_o;
	logic [4:0] wb_addr_o;
	logic [31:0] wb_data_o;

	logic [31:0] dmem [0:255];	// seen by the DUT
	logic [31:0] ref_mem [0:255];	// program-order copy
	logic [31:0] regs_m [0:31];
	logic [31:0] pc_q;
	wr_t exp_q [$];
	wr_t got;
	int seed = 77391;
	int errors = 0;
	int err_mark = 0;
	int n_pass = 0;
	int n_fail = 0;
	logic stall_seen = 1'b0;

	localparam logic [31:0] SHADOW = {12'h7ff, 5'd0, 3'd0, 5'd31, 7'b0010011};	// addi x31

	rv_pipe_top uut (.clk_i(clk), .arst_n_i(arst_n_i), .insn_valid_i(insn_valid_i),
		.pc_i(pc_i), .insn_i(insn_i), .stall_o(stall_o), .br_taken_o(br_taken_o),
		.br_addr_o(br_addr_o), .mem_op_o(mem_op_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i), .wb_valid_o(wb_valid_o),
		.wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o));

	always #20 clk = ~clk;

	// ------------------------------
	// data memory
	// ------------------------------
	assign mem_rdata_i = dmem[mem_addr_o[9:2]];

	always @(posedge clk)
	begin
		logic [3:0] be;
		be = 4'h0;
		case (mem_op_o)
			rv_pipe_pkg::MEM_SB: be = 4'b0001 << mem_addr_o[1:0];
			rv_pipe_pkg::MEM_SH: be = 4'b0011 << {mem_addr_o[1], 1'b0};
			rv_pipe_pkg::MEM_SW: be = 4'b1111;
			default:             be = 4'h0;
		endcase
		for (int b = 0; b < 4; b++)
			if (be[b])
				dmem[mem_addr_o[9:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic fail_val(input string name, input logic [31:0] got_v, input logic [31:0] exp_v);
		$display("FAIL %s got %h expected %h", name, got_v, exp_v);
		errors++;
	endtask

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// RV32I arithmetic and compare rules
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic cmp_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic expect_wr(input logic [4:0] rd, input logic [31:0] v);
		if (rd != 5'd0)
		begin
			regs_m[rd] = v;
			exp_q.push_back('{addr: rd, data: v});
		end
	endtask

	// present one instruction and hold it until accepted
	task automatic issue(input logic [31:0] insn);
		int n;
		@(negedge clk);
		insn_valid_i = 1'b1;
		insn_i       = insn;
		pc_i         = pc_q;
		n            = 0;
		#10;
		while (stall_o && n < 20)
		begin
			stall_seen = 1'b1;
			@(negedge clk);
			#10;
			n++;
		end
		if (stall_o)
		begin
			$display("instruction at pc %h was never accepted", pc_q);
			errors++;
		end
		@(posedge clk);
		pc_q = pc_q + 32'd4;
	endtask

	// cycle after a branch or jump, the presented instruction is squashed
	task automatic redirect(input logic taken, input logic [31:0] target);
		@(negedge clk);
		assert (br_taken_o == taken)
			else fail_val("br_taken_o", {31'b0, br_taken_o}, {31'b0, taken});
		if (taken)
		begin
			assert (br_addr_o == target) else fail_val("br_addr_o", br_addr_o, target);
			insn_i = SHADOW;
			pc_i   = pc_q;
			pc_q   = target;
		end
		insn_valid_i = taken;
		@(posedge clk);
	endtask

	task automatic do_opi(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		logic [31:0] v;
		v = alu_ref(f3, f3 == 3'd5 && imm[10], regs_m[rs1], sext12(imm));
		issue(enc_i(imm, rs1, f3, rd, 7'b0010011));
		expect_wr(rd, v);
	endtask

	task automatic do_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		logic [31:0] v;
		v = alu_ref(f3, alt, regs_m[rs1], regs_m[rs2]);
		issue(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
		expect_wr(rd, v);
	endtask

	task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm);
		issue({imm, rd, 7'b0110111});
		expect_wr(rd, {imm, 12'b0});
	endtask

	task automatic drain();
		int n;
		@(negedge clk);
		insn_valid_i = 1'b0;
		n = 0;
		while (exp_q.size() != 0 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d expected register writes never appeared", exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark)
			n_pass++;
		else
			n_fail++;
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// ------------------------------
	// writeback monitor
	// ------------------------------
	always @(negedge clk)
	begin
		if (arst_n_i && wb_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected register write to x%0d", wb_addr_o);
				errors++;
			end
			else
			begin
				got = exp_q.pop_front();
				assert (wb_addr_o == got.addr)
					else fail_val("wb_addr_o", {27'b0, wb_addr_o}, {27'b0, got.addr});
				assert (wb_data_o == got.data) else fail_val("wb_data_o", wb_data_o, got.data);
			end
		end
	end

	task automatic check_idle();
		assert (!wb_valid_o && !br_taken_o && !stall_o && mem_op_o == rv_pipe_pkg::MEM_NOP)
		else
		begin
			$display("control outputs are active while idle after reset");
			errors++;
		end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic test_reset();
		arst_n_i = 1'b0;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge clk);
			check_idle();
		end
		arst_n_i = 1'b1;
		for (int i = 0; i < 3; i++)
		begin
			@(negedge clk);
			check_idle();
		end
		end_test("reset");
	endtask

	task automatic test_alu();
		logic [31:0] r;
		logic [31:0] v;
		logic alt;
		for (int i = 1; i <= 8; i++)
		begin
			v = $random(seed);
			do_lui(5'(i), v[31:12]);
			do_opi(3'd0, 5'(i), 5'(i), v[11:0]);	// EX forward from lui
		end
		do_op(3'd0, 1'b0, 5'd10, 5'd1, 5'd2);
		do_op(3'd0, 1'b1, 5'd11, 5'd10, 5'd3);	// EX forward
		do_op(3'd4, 1'b0, 5'd12, 5'd10, 5'd11);	// MEM and EX forward
		do_opi(3'd0, 5'd0, 5'd12, 12'h0ff);	// write to x0 is dropped
		do_op(3'd0, 1'b0, 5'd13, 5'd0, 5'd12);	// x0 still reads zero
		for (int i = 0; i < 40; i++)
		begin
			r   = $random(seed);
			alt = r[3] && (r[2:0] == 3'd5 || (r[2:0] == 3'd0 && !r[31]));
			if (r[31])
				do_opi(r[2:0], 5'd1 + 5'(r[24:21]), 5'd1 + 5'(r[28:25]),
					(r[1:0] == 2'b01) ? {1'b0, alt, 5'b0, r[8:4]} : r[20:9]);
			else
				do_op(r[2:0], alt, 5'd1 + 5'(r[24:21]), 5'd1 + 5'(r[28:25]),
					5'd1 + 5'(r[12:9]));
		end
		drain();
		end_test("alu");
	endtask

	task automatic test_jump();
		logic [31:0] cur;
		do_lui(5'd3, 20'h12345);
		cur = pc_q;
		issue({20'h00010, 5'd4, 7'b0010111});
		expect_wr(5'd4, cur + 32'h00010000);
		cur = pc_q;
		issue(enc_j(21'h40, 5'd5));
		expect_wr(5'd5, cur + 32'd4);
		redirect(1'b1, cur + 32'h40);
		do_opi(3'd0, 5'd6, 5'd0, 12'h101);
		cur = pc_q;
		issue(enc_i(12'h020, 5'd6, 3'd0, 5'd7, 7'b1100111));
		expect_wr(5'd7, cur + 32'd4);
		redirect(1'b1, 32'h120);	// bit 0 of 0x121 cleared
		drain();
		end_test("jump");
	endtask

	task automatic test_branch();
		logic [2:0] f3s [0:5];
		logic [11:0] pa [0:2];
		logic [11:0] pb [0:2];
		logic [31:0] cur;
		logic t;
		f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		pa  = '{12'd5, 12'hffd, 12'd2};
		pb  = '{12'd5, 12'd2, 12'hffd};
		for (int f = 0; f < 6; f++)
			for (int p = 0; p < 3; p++)
			begin
				do_opi(3'd0, 5'd1, 5'd0, pa[p]);
				do_opi(3'd0, 5'd2, 5'd0, pb[p]);
				t   = cmp_ref(f3s[f], regs_m[1], regs_m[2]);
				cur = pc_q;
				issue(enc_b(13'h010, 5'd2, 5'd1, f3s[f]));
				redirect(t, cur + 32'h10);
			end
		drain();
		end_test("branch");
	endtask

	task automatic do_store(input logic [2:0] f3, input logic [11:0] off);
		logic [31:0] a;
		a = regs_m[8] + sext12(off);
		case (f3)
			3'd0: ref_mem[a[9:2]][{a[1:0], 3'b0} +: 8] = regs_m[9][7:0];
			3'd1: ref_mem[a[9:2]][{a[1], 4'b0} +: 16] = regs_m[9][15:0];
			default: ref_mem[a[9:2]] = regs_m[9];
		endcase
		issue(enc_s(off, 5'd9, 5'd8, f3));
	endtask

	task automatic do_load(input logic [2:0] f3, input logic [11:0] off);
		logic [31:0] a;
		logic [31:0] w;
		a = regs_m[8] + sext12(off);
		w = ref_mem[a[9:2]] >> {a[1:0], 3'b0};
		case (f3)
			3'd0: w = {{24{w[7]}}, w[7:0]};
			3'd1: w = {{16{w[15]}}, w[15:0]};
			3'd4: w = {24'b0, w[7:0]};
			3'd5: w = {16'b0, w[15:0]};
			default: w = w;
		endcase
		issue(enc_i(off, 5'd8, f3, 5'd10, 7'b0000011));
		expect_wr(5'd10, w);
		do_opi(3'd0, 5'd11, 5'd10, 12'd1);	// load-use, stalls one cycle
	endtask

	task automatic test_mem();
		logic [31:0] v;
		v = $random(seed) | 32'h80808080;	// sign bits set in every lane
		do_opi(3'd0, 5'd8, 5'd0, 12'h040);
		do_lui(5'd9, v[31:12] + 20'(v[11]));	// upper part rounded for the addi
		do_opi(3'd0, 5'd9, 5'd9, v[11:0]);
		do_store(3'd2, 12'd0);
		do_store(3'd1, 12'd6);
		do_store(3'd0, 12'd9);
		do_load(3'd2, 12'd0);
		do_load(3'd1, 12'd6);
		do_load(3'd5, 12'd6);
		do_load(3'd0, 12'd9);
		do_load(3'd4, 12'd9);
		do_load(3'd1, 12'd2);
		do_load(3'd4, 12'h13);
		drain();
		if (!stall_seen)
		begin
			$display("a load followed by a dependent instruction raised no stall");
			errors++;
		end
		end_test("memory");
	endtask

	initial
	begin
		repeat (20000) @(posedge clk);
		$display("simulation timed out");
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		arst_n_i     = 1'b0;
		insn_valid_i = 1'b0;
		insn_i       = 32'h0;
		pc_i         = 32'h0;
		pc_q         = 32'h100;
		for (int i = 0; i < 256; i++)
		begin
			dmem[i]    = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
			ref_mem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			regs_m[i] = 32'h0;
		test_reset();
		test_alu();
		test_jump();
		test_branch();
		test_mem();
		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== rv_pipe.f ====
src/rv_pipe_pkg.sv
src/gpr_file.sv
src/decoder.sv
src/ex_stage.sv
src/mem_stage.sv
src/rv_pipe_top.sv
tests/rv_pipe_checker.sv
tests/rv_pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_pipe_tb
FLIST     ?= rv_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
